/* hw/core_types_pkg.sv */
// Core types: branch prediction table geometry and the widths shared by the fetch pipeline
`default_nettype none

package core_types_pkg;

    // ----------------------------------------------------------------------
    // Context widths

    localparam int GH_LENGTH = 8;
    localparam int ASID_WIDTH = 4;

    // ----------------------------------------------------------------------
    // Global branch prediction table geometry

    // Eight 2-bit counters share one array word
    localparam int GBPT_ENTRIES_PER_BLOCK = 8;
    localparam int LOG_GBPT_ENTRIES_PER_BLOCK = $clog2(GBPT_ENTRIES_PER_BLOCK);

    localparam int GBPT_SETS = 64;
    localparam int GBPT_INDEX_WIDTH = $clog2(GBPT_SETS);

    // ----------------------------------------------------------------------
    // Typedefs

    typedef logic [31:0] pc_t;
    typedef logic [GH_LENGTH-1:0] gh_t;
    typedef logic [ASID_WIDTH-1:0] asid_t;

    typedef logic [GBPT_INDEX_WIDTH-1:0] gbpt_index_t;
    typedef logic [LOG_GBPT_ENTRIES_PER_BLOCK-1:0] gbpt_entry_t;

    // Entry k sits in bits 2k+1:2k, the upper bit is the prediction
    typedef logic [2*GBPT_ENTRIES_PER_BLOCK-1:0] gbpt_block_t;

endpackage

`default_nettype wire

/* hw/gbpt_index_hash.sv */
// GBPT index hash: folds fetch PC, global history and ASID into a set index and entry
`timescale 1ns/1ps
`default_nettype none

module gbpt_index_hash (
    input  wire core_types_pkg::pc_t   PC,
    input  wire core_types_pkg::gh_t   GH,
    input  wire core_types_pkg::asid_t ASID,

    output core_types_pkg::gbpt_index_t index,
    output core_types_pkg::gbpt_entry_t entry
);

    // ----------------------------------------------------------------------
    // Fold terms, all at the full set index plus entry width

    logic [core_types_pkg::GBPT_INDEX_WIDTH+core_types_pkg::LOG_GBPT_ENTRIES_PER_BLOCK-1:0]
        pc_term;
    logic [core_types_pkg::GBPT_INDEX_WIDTH+core_types_pkg::LOG_GBPT_ENTRIES_PER_BLOCK-1:0]
        gh_term;
    logic [core_types_pkg::GBPT_INDEX_WIDTH+core_types_pkg::LOG_GBPT_ENTRIES_PER_BLOCK-1:0]
        asid_term;
    logic [core_types_pkg::GBPT_INDEX_WIDTH+core_types_pkg::LOG_GBPT_ENTRIES_PER_BLOCK-1:0]
        fold;

    // Word aligned PC bits, byte offset dropped
    assign pc_term = PC[core_types_pkg::GBPT_INDEX_WIDTH
                        + core_types_pkg::LOG_GBPT_ENTRIES_PER_BLOCK + 1:2];

    // History shifted up by one so the newest outcome misses bit 0
    assign gh_term = {GH, 1'b0};

    assign asid_term = {
        {(core_types_pkg::GBPT_INDEX_WIDTH + core_types_pkg::LOG_GBPT_ENTRIES_PER_BLOCK
          - core_types_pkg::ASID_WIDTH){1'b0}},
        ASID
    };

    assign fold = pc_term ^ gh_term ^ asid_term;

    // ----------------------------------------------------------------------
    // Split: upper bits pick the set, lower bits the counter inside it

    assign index = fold[core_types_pkg::GBPT_INDEX_WIDTH
                        + core_types_pkg::LOG_GBPT_ENTRIES_PER_BLOCK - 1
                        : core_types_pkg::LOG_GBPT_ENTRIES_PER_BLOCK];
    assign entry = fold[core_types_pkg::LOG_GBPT_ENTRIES_PER_BLOCK-1:0];

endmodule

`default_nettype wire

/* hw/bram_2rport_1wport.sv */
// Counter array: GBPT block storage with two synchronous read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module bram_2rport_1wport (
    input  wire logic CLK,
    input  wire logic nRST,

    // Read port 0, prediction lookups
    input  wire logic                        port0_ren,
    input  wire core_types_pkg::gbpt_index_t port0_rindex,
    output core_types_pkg::gbpt_block_t      port0_rdata,

    // Read port 1, update reads
    input  wire logic                        port1_ren,
    input  wire core_types_pkg::gbpt_index_t port1_rindex,
    output core_types_pkg::gbpt_block_t      port1_rdata,

    // Write port
    input  wire logic                        wen,
    input  wire core_types_pkg::gbpt_index_t windex,
    input  wire core_types_pkg::gbpt_block_t wdata
);

    // ----------------------------------------------------------------------
    // Storage

    core_types_pkg::gbpt_block_t mem [core_types_pkg::GBPT_SETS];

    // Whole table clears on reset so every counter starts strongly not taken
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            for (int i = 0; i < core_types_pkg::GBPT_SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            mem[windex] <= wdata;
        end
    end

    // ----------------------------------------------------------------------
    // Read ports
    //
    // Both sample mem before this edge's write lands, so a read and a
    // write to the same set in one cycle return the old word

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            port0_rdata <= '0;
        end else if (port0_ren) begin
            port0_rdata <= mem[port0_rindex];
        end
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            port1_rdata <= '0;
        end else if (port1_ren) begin
            port1_rdata <= mem[port1_rindex];
        end
    end

endmodule

`default_nettype wire

/* hw/gbpt.sv */
// Global branch prediction table with 2-bit counter lookup and read-modify-write update pipeline
`timescale 1ns/1ps
`default_nettype none

module gbpt (
    input  wire logic CLK,
    input  wire logic nRST,

    // RESP stage lookup
    input  wire logic                  valid_RESP,
    input  wire core_types_pkg::pc_t   full_PC_RESP,
    input  wire core_types_pkg::gh_t   GH_RESP,
    input  wire core_types_pkg::asid_t ASID_RESP,

    // RESTART stage prediction
    output logic pred_taken_RESTART,

    // Update 0 request
    input  wire logic                  update0_valid,
    input  wire core_types_pkg::pc_t   update0_start_full_PC,
    input  wire core_types_pkg::gh_t   update0_GH,
    input  wire core_types_pkg::asid_t update0_ASID,
    input  wire logic                  update0_taken,

    // Update 1 result
    output logic update1_correct
);

    // ----------------------------------------------------------------------
    // Signals

    // RESP / RESTART
    core_types_pkg::gbpt_index_t resp_index;
    core_types_pkg::gbpt_entry_t resp_entry;
    core_types_pkg::gbpt_entry_t restart_entry;
    core_types_pkg::gbpt_block_t restart_block;

    // Update 0
    core_types_pkg::gbpt_index_t update0_index;
    core_types_pkg::gbpt_entry_t update0_entry;

    // Update 1
    logic                        update1_valid;
    core_types_pkg::gbpt_index_t update1_index;
    core_types_pkg::gbpt_entry_t update1_entry;
    logic                        update1_taken;
    core_types_pkg::gbpt_block_t update1_read_block;
    core_types_pkg::gbpt_block_t update1_base_block;
    core_types_pkg::gbpt_block_t update1_new_block;
    logic [1:0]                  update1_old_state;
    logic [1:0]                  update1_new_state;

    // Same-set forwarding
    logic                        last_update1_conflict;
    core_types_pkg::gbpt_block_t last_update1_block;

    // ----------------------------------------------------------------------
    // Prediction path

    gbpt_index_hash resp_hash (
        .PC    (full_PC_RESP),
        .GH    (GH_RESP),
        .ASID  (ASID_RESP),
        .index (resp_index),
        .entry (resp_entry)
    );

    // Entry follows the array read and holds while no lookup is issued
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            restart_entry <= '0;
        end else if (valid_RESP) begin
            restart_entry <= resp_entry;
        end
    end

    // Prediction bit of entry k is bit 2k+1
    assign pred_taken_RESTART = restart_block[{restart_entry, 1'b1}];

    // ----------------------------------------------------------------------
    // Update 0

    gbpt_index_hash update_hash (
        .PC    (update0_start_full_PC),
        .GH    (update0_GH),
        .ASID  (update0_ASID),
        .index (update0_index),
        .entry (update0_entry)
    );

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            update1_valid <= 1'b0;
            update1_index <= '0;
            update1_entry <= '0;
            update1_taken <= 1'b0;
            last_update1_conflict <= 1'b0;
        end else begin
            update1_valid <= update0_valid;
            update1_index <= update0_index;
            update1_entry <= update0_entry;
            update1_taken <= update0_taken;
            // Array read this cycle misses the write going on in the same set
            last_update1_conflict <= update0_valid && update1_valid
                                     && (update0_index == update1_index);
        end
    end

    // Block written this cycle for a same-set Update 1 to reuse
    always_ff @(posedge CLK) begin
        last_update1_block <= update1_new_block;
    end

    // ----------------------------------------------------------------------
    // Update 1 counter read-modify-write

    assign update1_base_block = last_update1_conflict ? last_update1_block
                                                      : update1_read_block;

    assign update1_old_state = update1_base_block[{update1_entry, 1'b0} +: 2];

    // 2-bit saturating counter where a miss from either weak state drops to 00
    always_comb begin
        case ({update1_old_state, update1_taken})
            3'b000:  update1_new_state = 2'b00;
            3'b001:  update1_new_state = 2'b01;
            3'b010:  update1_new_state = 2'b00;
            3'b011:  update1_new_state = 2'b11;
            3'b100:  update1_new_state = 2'b00;
            3'b101:  update1_new_state = 2'b11;
            3'b110:  update1_new_state = 2'b10;
            default: update1_new_state = 2'b11;
        endcase
    end

    // Rest of the set passes through unchanged
    always_comb begin
        update1_new_block = update1_base_block;
        update1_new_block[{update1_entry, 1'b0} +: 2] = update1_new_state;
    end

    assign update1_correct = (update1_old_state[1] == update1_taken);

    // ----------------------------------------------------------------------
    // Counter array

    bram_2rport_1wport gbpt_array (
        .CLK          (CLK),
        .nRST         (nRST),
        .port0_ren    (valid_RESP),
        .port0_rindex (resp_index),
        .port0_rdata  (restart_block),
        .port1_ren    (update0_valid),
        .port1_rindex (update0_index),
        .port1_rdata  (update1_read_block),
        .wen          (update1_valid),
        .windex       (update1_index),
        .wdata        (update1_new_block)
    );

endmodule

`default_nettype wire

/* tests/gbpt_assertions.sv */
// GBPT checker with concurrent assertions on the array write strobe, outputs and reset state
`timescale 1ns/1ps
`default_nettype none

module gbpt_assertions (
    input wire logic CLK,
    input wire logic nRST,
    input wire logic update0_valid,
    input wire logic array_wen,
    input wire logic last_update1_conflict,
    input wire logic pred_taken_RESTART,
    input wire logic update1_correct
);

    // Assertion failures seen so far
    int fail_count = 0;

    // Array write enable only one cycle after an update strobe
    write_follows_update: assert property (
        @(posedge CLK) disable iff (!nRST)
        array_wen |-> $past(update0_valid)
    ) else begin
        fail_count++;
        $error("array write without an update strobe one cycle earlier");
    end

    outputs_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        !$isunknown({pred_taken_RESTART, update1_correct})
    ) else begin
        fail_count++;
        $error("prediction or correctness output is unknown");
    end

    conflict_clear_after_reset: assert property (
        @(posedge CLK)
        !nRST |=> !last_update1_conflict
    ) else begin
        fail_count++;
        $error("same-set conflict flag set in the cycle after reset");
    end

endmodule

bind gbpt gbpt_assertions assertions_inst (
    .CLK                   (CLK),
    .nRST                  (nRST),
    .update0_valid         (update0_valid),
    .array_wen             (gbpt_array.wen),
    .last_update1_conflict (last_update1_conflict),
    .pred_taken_RESTART    (pred_taken_RESTART),
    .update1_correct       (update1_correct)
);

`default_nettype wire

/* tests/gbpt_tb.sv */
// GBPT testbench with table driven lookups and updates checked against precomputed counter states
`timescale 1ns/1ps
`default_nettype none

module gbpt_tb;

    localparam int OP_IDLE = 0;
    localparam int OP_PRED = 1;
    localparam int OP_UPD = 2;
    localparam int OP_BOTH = 3;
    localparam int MAX_ROWS = 64;
    localparam int NUM_TESTS = 5;
    localparam int SETTLE_CYCLES = 20;
    localparam int WATCHDOG_NS = 20000;

    logic CLK;
    logic nRST;
    logic valid_RESP;
    core_types_pkg::pc_t full_PC_RESP;
    core_types_pkg::gh_t GH_RESP;
    core_types_pkg::asid_t ASID_RESP;
    logic pred_taken_RESTART;
    logic update0_valid;
    core_types_pkg::pc_t update0_start_full_PC;
    core_types_pkg::gh_t update0_GH;
    core_types_pkg::asid_t update0_ASID;
    logic update0_taken;
    logic update1_correct;

    // Stimulus table with one row per cycle
    int test_tab [MAX_ROWS];
    int op_tab [MAX_ROWS];
    core_types_pkg::pc_t pc_tab [MAX_ROWS];
    core_types_pkg::gh_t gh_tab [MAX_ROWS];
    core_types_pkg::asid_t asid_tab [MAX_ROWS];
    logic taken_tab [MAX_ROWS];
    logic exp_pred_tab [MAX_ROWS];
    logic exp_corr_tab [MAX_ROWS];
    int num_rows;

    string test_names [NUM_TESTS];
    int test_checks [NUM_TESTS];
    int test_errors [NUM_TESTS];
    int total_checks;
    int total_errors;
    int wait_count;

    gbpt gbpt_inst (
        .CLK                   (CLK),
        .nRST                  (nRST),
        .valid_RESP            (valid_RESP),
        .full_PC_RESP          (full_PC_RESP),
        .GH_RESP               (GH_RESP),
        .ASID_RESP             (ASID_RESP),
        .pred_taken_RESTART    (pred_taken_RESTART),
        .update0_valid         (update0_valid),
        .update0_start_full_PC (update0_start_full_PC),
        .update0_GH            (update0_GH),
        .update0_ASID          (update0_ASID),
        .update0_taken         (update0_taken),
        .update1_correct       (update1_correct)
    );

    always #50 CLK = ~CLK;

    // ----------------------------------------------------------------------
    // Table handling

    task automatic add_row(input int test, input int op, input core_types_pkg::pc_t pc,
                           input core_types_pkg::gh_t gh, input core_types_pkg::asid_t asid,
                           input logic taken, input logic exp_pred, input logic exp_corr);
        test_tab[num_rows] = test;
        op_tab[num_rows] = op;
        pc_tab[num_rows] = pc;
        gh_tab[num_rows] = gh;
        asid_tab[num_rows] = asid;
        taken_tab[num_rows] = taken;
        exp_pred_tab[num_rows] = exp_pred;
        exp_corr_tab[num_rows] = exp_corr;
        num_rows++;
    endtask

    // Columns are test, operation, PC, GH, ASID, taken, expected prediction and expected correct
    // Counter positions from the hash are 0x010 in set 0 entry 4 and 0x020 in set 1 entry 0
    // 0x020 with GH 1 is entry 2 and with GH 1 plus ASID 1 entry 3
    // 0x080 and 0x084 are set 4 entries 0 and 1
    task automatic fill_table();
        test_names[0] = "reset state";
        test_names[1] = "counter walk";
        test_names[2] = "hash selection";
        test_names[3] = "back-to-back updates";
        test_names[4] = "predictions during updates";
        num_rows = 0;
        add_row(0, OP_PRED, 32'h0000_0100, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(0, OP_PRED, 32'h0000_0204, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(0, OP_PRED, 32'h0000_07fc, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(0, OP_UPD, 32'h0000_0300, 8'h00, 4'h0, 1'b0, 1'b0, 1'b1);
        add_row(0, OP_UPD, 32'h0000_0400, 8'h00, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(0, OP_IDLE, 32'h0, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        // 00 -> 01 -> 11 and then 11 -> 10 -> 00 -> 00
        add_row(1, OP_UPD, 32'h0000_0010, 8'h00, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(1, OP_UPD, 32'h0000_0010, 8'h00, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(1, OP_IDLE, 32'h0, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1, OP_PRED, 32'h0000_0010, 8'h00, 4'h0, 1'b0, 1'b1, 1'b0);
        add_row(1, OP_UPD, 32'h0000_0010, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1, OP_UPD, 32'h0000_0010, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1, OP_UPD, 32'h0000_0010, 8'h00, 4'h0, 1'b0, 1'b0, 1'b1);
        add_row(1, OP_IDLE, 32'h0, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(1, OP_PRED, 32'h0000_0010, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        // Train only the GH variant
        add_row(2, OP_UPD, 32'h0000_0020, 8'h01, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(2, OP_UPD, 32'h0000_0020, 8'h01, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(2, OP_IDLE, 32'h0, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(2, OP_PRED, 32'h0000_0020, 8'h01, 4'h0, 1'b0, 1'b1, 1'b0);
        add_row(2, OP_PRED, 32'h0000_0020, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(2, OP_PRED, 32'h0000_0020, 8'h01, 4'h1, 1'b0, 1'b0, 1'b0);
        // Same entry every cycle and then two entries of one set interleaved
        add_row(3, OP_UPD, 32'h0000_0040, 8'h00, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(3, OP_UPD, 32'h0000_0040, 8'h00, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(3, OP_UPD, 32'h0000_0040, 8'h00, 4'h0, 1'b1, 1'b0, 1'b1);
        add_row(3, OP_IDLE, 32'h0, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(3, OP_PRED, 32'h0000_0040, 8'h00, 4'h0, 1'b0, 1'b1, 1'b0);
        add_row(3, OP_UPD, 32'h0000_0080, 8'h00, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(3, OP_UPD, 32'h0000_0084, 8'h00, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(3, OP_UPD, 32'h0000_0080, 8'h00, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(3, OP_UPD, 32'h0000_0084, 8'h00, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(3, OP_IDLE, 32'h0, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(3, OP_PRED, 32'h0000_0080, 8'h00, 4'h0, 1'b0, 1'b1, 1'b0);
        add_row(3, OP_PRED, 32'h0000_0084, 8'h00, 4'h0, 1'b0, 1'b1, 1'b0);
        // First lookup overlaps the 01 -> 11 write and still sees 01
        add_row(4, OP_UPD, 32'h0000_0500, 8'h00, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(4, OP_UPD, 32'h0000_0500, 8'h00, 4'h0, 1'b1, 1'b0, 1'b0);
        add_row(4, OP_PRED, 32'h0000_0500, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(4, OP_PRED, 32'h0000_0500, 8'h00, 4'h0, 1'b0, 1'b1, 1'b0);
        add_row(4, OP_BOTH, 32'h0000_0500, 8'h00, 4'h0, 1'b0, 1'b1, 1'b0);
        add_row(4, OP_BOTH, 32'h0000_0500, 8'h00, 4'h0, 1'b0, 1'b1, 1'b0);
        add_row(4, OP_IDLE, 32'h0, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
        add_row(4, OP_PRED, 32'h0000_0500, 8'h00, 4'h0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic apply_idle();
        valid_RESP = 1'b0;
        full_PC_RESP = '0;
        GH_RESP = '0;
        ASID_RESP = '0;
        update0_valid = 1'b0;
        update0_start_full_PC = '0;
        update0_GH = '0;
        update0_ASID = '0;
        update0_taken = 1'b0;
    endtask

    task automatic drive_row(input int row);
        valid_RESP = (op_tab[row] == OP_PRED) || (op_tab[row] == OP_BOTH);
        full_PC_RESP = pc_tab[row];
        GH_RESP = gh_tab[row];
        ASID_RESP = asid_tab[row];
        update0_valid = (op_tab[row] == OP_UPD) || (op_tab[row] == OP_BOTH);
        update0_start_full_PC = pc_tab[row];
        update0_GH = gh_tab[row];
        update0_ASID = asid_tab[row];
        update0_taken = taken_tab[row];
    endtask

    task automatic check_row(input int row);
        int t;
        t = test_tab[row];
        if ((op_tab[row] == OP_PRED) || (op_tab[row] == OP_BOTH)) begin
            test_checks[t]++;
            if (pred_taken_RESTART !== exp_pred_tab[row]) begin
                test_errors[t]++;
                $display("[FAIL] %0t: row %0d pred_taken_RESTART %b, expected %b",
                         $time, row, pred_taken_RESTART, exp_pred_tab[row]);
            end
        end
        if ((op_tab[row] == OP_UPD) || (op_tab[row] == OP_BOTH)) begin
            test_checks[t]++;
            if (update1_correct !== exp_corr_tab[row]) begin
                test_errors[t]++;
                $display("[FAIL] %0t: row %0d update1_correct %b, expected %b",
                         $time, row, update1_correct, exp_corr_tab[row]);
            end
        end
        // Last row of a test closes it
        if ((row == num_rows - 1) || (test_tab[row + 1] != t)) begin
            $display("Test %0d, %s: %0d checks, %0d errors",
                     t + 1, test_names[t], test_checks[t], test_errors[t]);
        end
    endtask

    // Outputs of a row are checked one cycle after it is driven
    task automatic run_table();
        for (int i = 0; i <= num_rows; i++) begin
            @(posedge CLK);
            #5;
            if (i > 0) begin
                check_row(i - 1);
            end
            if (i < num_rows) begin
                drive_row(i);
            end else begin
                apply_idle();
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence

    initial begin
        CLK = 1'b0;
        nRST = 1'b0;
        apply_idle();
        fill_table();
        for (int i = 0; i < 10; i++) begin
            @(posedge CLK);
        end
        #5;
        nRST = 1'b1;
        wait_count = 0;
        while ($isunknown({pred_taken_RESTART, update1_correct})
               && (wait_count < SETTLE_CYCLES)) begin
            @(posedge CLK);
            wait_count++;
        end
        if (wait_count >= SETTLE_CYCLES) begin
            $display("Outputs stayed unknown after reset was released");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            run_table();
            total_checks = 0;
            total_errors = gbpt_inst.assertions_inst.fail_count;
            for (int t = 0; t < NUM_TESTS; t++) begin
                total_checks += test_checks[t];
                total_errors += test_errors[t];
            end
            $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                     total_checks, total_errors, gbpt_inst.assertions_inst.fail_count);
            if (total_errors == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

    // Hard limit on the whole run
    initial begin
        #WATCHDOG_NS;
        $display("Simulation did not finish within its time limit");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hw/core_types_pkg.sv
hw/gbpt_index_hash.sv
hw/bram_2rport_1wport.sv
hw/gbpt.sv
tests/gbpt_assertions.sv
tests/gbpt_tb.sv
